/* logic/vdp_pkg.sv */
package vdp_pkg;

  // ------------------------------
  // Beam geometry
  // ------------------------------

  // Frame length in half lines, CY units
  localparam logic [9:0] LINES_NTSC = 10'd524;
  localparam logic [9:0] LINES_PAL  = 10'd626;

  // Window in CY units, 192 lines of two half lines each
  localparam logic [9:0] WIN_Y_START = 10'd40;
  localparam logic [9:0] WIN_Y_LINES = 10'd384;

  localparam logic [9:0] WIN_X_START = 10'd64;
  localparam logic [9:0] WIN_X_END   = 10'd575;

  // Vertical flag sets at the window bottom
  localparam logic [9:0] VBLANK_LINE_NTSC = WIN_Y_START + WIN_Y_LINES;
  localparam logic [9:0] VBLANK_LINE_PAL  = WIN_Y_START + WIN_Y_LINES;

  // Line interrupt test point, right of the window
  localparam logic [9:0] HINT_X = 10'd600;

  // ------------------------------
  // CPU port map
  // ------------------------------
  localparam logic [1:0] ADDR_DATA     = 2'd0;
  localparam logic [1:0] ADDR_CTRL     = 2'd1;
  localparam logic [1:0] ADDR_PAL      = 2'd2;
  localparam logic [1:0] ADDR_INDIRECT = 2'd3;

  // Register numbers
  localparam logic [5:0] REG_R0  = 6'd0;
  localparam logic [5:0] REG_R1  = 6'd1;
  localparam logic [5:0] REG_R7  = 6'd7;
  localparam logic [5:0] REG_R9  = 6'd9;
  localparam logic [5:0] REG_R15 = 6'd15;
  localparam logic [5:0] REG_R16 = 6'd16;
  localparam logic [5:0] REG_R17 = 6'd17;
  localparam logic [5:0] REG_R19 = 6'd19;

  // ------------------------------
  // Shared types
  // ------------------------------

  // Decoded register fields seen outside the CPU port
  typedef struct packed {
    logic       hint_en;
    logic       disp_on;
    logic       vint_en;
    logic [3:0] backdrop;
    logic       pal_mode;
    logic [3:0] status_sel;
    logic [7:0] hint_line;
  } vdp_regs_t;

  typedef struct packed {
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [1:0] paddr;
    logic [7:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [7:0] prdata;
    logic       pready;
    logic       pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic [2:0] red;
    logic [2:0] green;
    logic [2:0] blue;
  } rgb9_t;

  // One palette entry update
  typedef struct packed {
    logic       en;
    logic [3:0] index;
    rgb9_t      rgb;
  } pal_wr_t;

endpackage

/* logic/vdp_cpu_port.sv */
`timescale 1ns/1ps

module vdp_cpu_port (
  input  logic                RESET,
  input  logic                CLK21M,
  input  vdp_pkg::apb_req_t   apb_req,
  output vdp_pkg::apb_rsp_t   apb_rsp,
  input  logic                vint_flag,
  input  logic                hint_flag,
  output vdp_pkg::vdp_regs_t  regs,
  output logic                clr_vint,
  output logic                clr_hint,
  output vdp_pkg::pal_wr_t    pal_wr
);

  logic       access;
  logic       ctrl_wr;
  logic       ctrl_rd;
  logic       pal_port_wr;
  logic       ind_wr;
  logic       ctrl_second;
  logic [7:0] ctrl_data;
  logic       pal_second;
  logic [2:0] pal_red;
  logic [2:0] pal_blue;
  logic [3:0] pal_ptr;
  logic [5:0] ind_num;
  logic       ind_no_inc;
  logic       reg_wr;
  logic [5:0] reg_num;
  logic [7:0] reg_data;
  logic [7:0] status_byte;

  // ------------------------------
  // APB decode
  // ------------------------------
  assign access      = apb_req.psel && apb_req.penable;
  assign ctrl_wr     = access && apb_req.pwrite && (apb_req.paddr == vdp_pkg::ADDR_CTRL);
  assign ctrl_rd     = access && !apb_req.pwrite && (apb_req.paddr == vdp_pkg::ADDR_CTRL);
  assign pal_port_wr = access && apb_req.pwrite && (apb_req.paddr == vdp_pkg::ADDR_PAL);
  assign ind_wr      = access && apb_req.pwrite && (apb_req.paddr == vdp_pkg::ADDR_INDIRECT);

  // Second control byte with bit 7 set, or any indirect write
  always_comb begin
    reg_wr   = 1'b0;
    reg_num  = ind_num;
    reg_data = apb_req.pwdata;
    if (ctrl_wr && ctrl_second && apb_req.pwdata[7]) begin
      reg_wr   = 1'b1;
      reg_num  = apb_req.pwdata[5:0];
      reg_data = ctrl_data;
    end else if (ind_wr) begin
      reg_wr = 1'b1;
    end
  end

  // ------------------------------
  // Register file
  // ------------------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      regs       <= '0;
      pal_ptr    <= 4'd0;
      ind_num    <= 6'd0;
      ind_no_inc <= 1'b0;
    end else begin
      if (ind_wr && !ind_no_inc) begin
        ind_num <= ind_num + 6'd1;
      end
      // Pointer wraps after entry 15
      if (pal_port_wr && pal_second) begin
        pal_ptr <= pal_ptr + 4'd1;
      end
      if (reg_wr) begin
        case (reg_num)
          vdp_pkg::REG_R0: regs.hint_en <= reg_data[4];
          vdp_pkg::REG_R1: begin
            regs.disp_on <= reg_data[6];
            regs.vint_en <= reg_data[5];
          end
          vdp_pkg::REG_R7:  regs.backdrop <= reg_data[3:0];
          vdp_pkg::REG_R9:  regs.pal_mode <= reg_data[1];
          vdp_pkg::REG_R15: regs.status_sel <= reg_data[3:0];
          vdp_pkg::REG_R16: pal_ptr <= reg_data[3:0];
          vdp_pkg::REG_R17: begin
            ind_num    <= reg_data[5:0];
            ind_no_inc <= reg_data[7];
          end
          vdp_pkg::REG_R19: regs.hint_line <= reg_data;
          default: ;
        endcase
      end
    end
  end

  // Pair latches, a status read restarts the control pair
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      ctrl_second <= 1'b0;
      pal_second  <= 1'b0;
    end else begin
      if (ctrl_wr) begin
        ctrl_second <= !ctrl_second;
      end else if (ctrl_rd) begin
        ctrl_second <= 1'b0;
      end
      if (reg_wr && (reg_num == vdp_pkg::REG_R16)) begin
        pal_second <= 1'b0;
      end else if (pal_port_wr) begin
        pal_second <= !pal_second;
      end
    end
  end

  // First bytes of each pair
  always_ff @(posedge RESET) begin
    if (ctrl_wr && !ctrl_second) begin
      ctrl_data <= apb_req.pwdata;
    end
    if (pal_port_wr && !pal_second) begin
      pal_red  <= apb_req.pwdata[6:4];
      pal_blue <= apb_req.pwdata[2:0];
    end
  end

  always_comb begin
    pal_wr.en        = pal_port_wr && pal_second;
    pal_wr.index     = pal_ptr;
    pal_wr.rgb.red   = pal_red;
    pal_wr.rgb.green = apb_req.pwdata[2:0];
    pal_wr.rgb.blue  = pal_blue;
  end

  // ------------------------------
  // Status readback
  // ------------------------------
  always_comb begin
    case (regs.status_sel)
      4'd0:    status_byte = {vint_flag, 7'b0};
      4'd1:    status_byte = {7'b0, hint_flag};
      default: status_byte = 8'h00;
    endcase
  end

  // Read of S0 or S1 clears its flag
  assign clr_vint = ctrl_rd && (regs.status_sel == 4'd0);
  assign clr_hint = ctrl_rd && (regs.status_sel == 4'd1);

  assign apb_rsp.prdata  = ctrl_rd ? status_byte : 8'h00;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && (apb_req.paddr == vdp_pkg::ADDR_DATA);

endmodule

/* logic/vdp_interrupt.sv */
`timescale 1ns/1ps

module vdp_interrupt (
  input  logic               RESET,
  input  logic               CLK21M,
  input  logic [9:0]         cx,
  input  logic [9:0]         cy,
  input  vdp_pkg::vdp_regs_t regs,
  input  logic               clr_vint,
  input  logic               clr_hint,
  output logic               vint_flag,
  output logic               hint_flag,
  output logic               int_n
);

  logic [9:0] frame_lines;
  logic [9:0] line_off;
  logic       vint_set;
  logic       hint_set;

  // Frame length from the R9 standard
  assign frame_lines = regs.pal_mode ? vdp_pkg::LINES_PAL : vdp_pkg::LINES_NTSC;

  // Both standards raise the vertical flag at the window bottom
  assign vint_set = (cy == vdp_pkg::VBLANK_LINE_NTSC) && (cx == 10'd0);

  // Half lines past the window top
  assign line_off = cy - vdp_pkg::WIN_Y_START;

  // Beam beyond the frame end carries no line interrupt
  assign hint_set = (cx == vdp_pkg::HINT_X) &&
                    (cy >= vdp_pkg::WIN_Y_START) &&
                    (cy < frame_lines) &&
                    !line_off[0] &&
                    (line_off[8:1] == regs.hint_line);

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      vint_flag <= 1'b0;
      hint_flag <= 1'b0;
      int_n     <= 1'b1;
    end else begin
      // Set wins over a clear in the same cycle
      if (vint_set) begin
        vint_flag <= 1'b1;
      end else if (clr_vint) begin
        vint_flag <= 1'b0;
      end
      if (hint_set) begin
        hint_flag <= 1'b1;
      end else if (clr_hint) begin
        hint_flag <= 1'b0;
      end
      int_n <= !((vint_flag && regs.vint_en) || (hint_flag && regs.hint_en));
    end
  end

endmodule

/* logic/vdp_display_window.sv */
`timescale 1ns/1ps

module vdp_display_window (
  input  logic       RESET,
  input  logic       CLK21M,
  input  logic [9:0] cx,
  input  logic [9:0] cy,
  output logic       in_window
);

  logic x_in;
  logic y_in;

  // ------------------------------
  // Range compares
  // ------------------------------

  // Horizontal range, both ends inclusive
  assign x_in = (cx >= vdp_pkg::WIN_X_START) && (cx <= vdp_pkg::WIN_X_END);

  // Vertical range, 192 lines from the window top
  assign y_in = (cy >= vdp_pkg::WIN_Y_START) &&
                (cy <= vdp_pkg::WIN_Y_START + vdp_pkg::WIN_Y_LINES - 10'd1);

  // ------------------------------
  // Output register
  // ------------------------------

  // One cycle behind the beam, in step with pixel_code
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      in_window <= 1'b0;
    end else begin
      in_window <= x_in && y_in;
    end
  end

endmodule

/* logic/vdp_color_out.sv */
`timescale 1ns/1ps

module vdp_color_out (
  input  logic               RESET,
  input  logic               CLK21M,
  input  vdp_pkg::vdp_regs_t regs,
  input  vdp_pkg::pal_wr_t   pal_wr,
  input  logic               in_window,
  input  logic [3:0]         pixel_code,
  input  logic               scanlin,
  input  logic               cy_odd,
  output logic [7:0]         red,
  output logic [7:0]         green,
  output logic [7:0]         blue
);

  vdp_pkg::rgb9_t palette [16];
  vdp_pkg::rgb9_t color;
  logic           cy_odd_d;
  logic [3:0]     color_idx;
  logic           darken;

  // 3 bits to 8 by bit repeat, halved on dark lines
  function automatic logic [7:0] expand(input logic [2:0] c, input logic dark);
    logic [7:0] full;
    full = {c, c, c[2:1]};
    return dark ? (full >> 1) : full;
  endfunction

  // ------------------------------
  // Palette RAM
  // ------------------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      for (int i = 0; i < 16; i++) begin
        palette[i] <= '0;
      end
    end else if (pal_wr.en) begin
      palette[pal_wr.index] <= pal_wr.rgb;
    end
  end

  // ------------------------------
  // Colour select
  // ------------------------------

  // Backdrop outside the window or with display off
  assign color_idx = (in_window && regs.disp_on) ? pixel_code : regs.backdrop;
  assign color     = palette[color_idx];

  // Line parity lines up with the delayed window flag
  assign darken = scanlin && cy_odd_d;

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      cy_odd_d <= 1'b0;
      red      <= 8'h00;
      green    <= 8'h00;
      blue     <= 8'h00;
    end else begin
      cy_odd_d <= cy_odd;
      red      <= expand(color.red, darken);
      green    <= expand(color.green, darken);
      blue     <= expand(color.blue, darken);
    end
  end

endmodule

/* logic/vdp_top.sv */
`timescale 1ns/1ps

module vdp_top (
  input  logic              RESET,
  input  logic              CLK21M,
  input  vdp_pkg::apb_req_t apb_req,
  output vdp_pkg::apb_rsp_t apb_rsp,
  input  logic [9:0]        cx,
  input  logic [9:0]        cy,
  input  logic [3:0]        pixel_code,
  input  logic              scanlin,
  output logic              int_n,
  output logic [7:0]        red,
  output logic [7:0]        green,
  output logic [7:0]        blue
);

  vdp_pkg::vdp_regs_t regs;
  vdp_pkg::pal_wr_t   pal_wr;
  logic               vint_flag;
  logic               hint_flag;
  logic               clr_vint;
  logic               clr_hint;
  logic               in_window;

  // ------------------------------
  // Register port
  // ------------------------------
  vdp_cpu_port u_cpu_port (
    .RESET     (RESET),
    .CLK21M    (CLK21M),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .vint_flag (vint_flag),
    .hint_flag (hint_flag),
    .regs      (regs),
    .clr_vint  (clr_vint),
    .clr_hint  (clr_hint),
    .pal_wr    (pal_wr)
  );

  vdp_interrupt u_interrupt (
    .RESET     (RESET),
    .CLK21M    (CLK21M),
    .cx        (cx),
    .cy        (cy),
    .regs      (regs),
    .clr_vint  (clr_vint),
    .clr_hint  (clr_hint),
    .vint_flag (vint_flag),
    .hint_flag (hint_flag),
    .int_n     (int_n)
  );

  // ------------------------------
  // Video path
  // ------------------------------
  vdp_display_window u_display_window (
    .RESET     (RESET),
    .CLK21M    (CLK21M),
    .cx        (cx),
    .cy        (cy),
    .in_window (in_window)
  );

  vdp_color_out u_color_out (
    .RESET      (RESET),
    .CLK21M     (CLK21M),
    .regs       (regs),
    .pal_wr     (pal_wr),
    .in_window  (in_window),
    .pixel_code (pixel_code),
    .scanlin    (scanlin),
    .cy_odd     (cy[0]),
    .red        (red),
    .green      (green),
    .blue       (blue)
  );

endmodule

/* tb/vdp_assertions.sv */
`timescale 1ns/1ps

module vdp_assertions (
  input logic               RESET,
  input logic               CLK21M,
  input vdp_pkg::apb_req_t  apb_req,
  input vdp_pkg::apb_rsp_t  apb_rsp,
  input vdp_pkg::vdp_regs_t regs,
  input logic               int_n
);

  int   fail_count = 0;
  logic access;

  assign access = apb_req.psel && apb_req.penable;

  // Zero-wait slave, every access cycle completes
  pready_in_access: assert property (
    @(posedge RESET) disable iff (CLK21M) access |-> apb_rsp.pready
  ) else begin
    $error("pready low in an APB access cycle");
    fail_count++;
  end

  // Error response only in the access cycle
  slverr_only_in_access: assert property (
    @(posedge RESET) disable iff (CLK21M) !access |-> !apb_rsp.pslverr
  ) else begin
    $error("pslverr high outside an APB access cycle");
    fail_count++;
  end

  // INT_N is registered, so it follows the enables one cycle later
  int_n_idle_when_disabled: assert property (
    @(posedge RESET) disable iff (CLK21M) (!regs.vint_en && !regs.hint_en) |=> int_n
  ) else begin
    $error("int_n low with both interrupt enables clear");
    fail_count++;
  end

endmodule

/* tb/tb_vdp.sv */
`timescale 1ns/1ps

module tb_vdp;

  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_BEAM, OP_PULSE, OP_INTN, OP_SCAN} op_t;

  // One table row
  typedef struct packed {
    logic [2:0]  grp;
    op_t         op;
    logic [1:0]  addr;
    logic [7:0]  data;
    logic [9:0]  cx;
    logic [9:0]  cy;
    logic [3:0]  pix;
    logic [23:0] expected;
  } step_t;

  logic              RESET;
  logic              CLK21M;
  vdp_pkg::apb_req_t apb_req;
  vdp_pkg::apb_rsp_t apb_rsp;
  logic [9:0]        cx;
  logic [9:0]        cy;
  logic [3:0]        pixel_code;
  logic              scanlin;
  logic              int_n;
  logic [7:0]        red;
  logic [7:0]        green;
  logic [7:0]        blue;

  step_t          steps [$];
  vdp_pkg::rgb9_t model_pal [16];
  logic [2:0]     cur_grp;
  logic [31:0]    lcg_state;
  logic           table_ready;
  int             errors;
  int             tests_passed;
  int             tests_failed;
  int             group_start;

  vdp_top u_dut (
    .RESET      (RESET),
    .CLK21M     (CLK21M),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .cx         (cx),
    .cy         (cy),
    .pixel_code (pixel_code),
    .scanlin    (scanlin),
    .int_n      (int_n),
    .red        (red),
    .green      (green),
    .blue       (blue)
  );

  bind vdp_top vdp_assertions u_assertions (
    .RESET   (RESET),
    .CLK21M  (CLK21M),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .regs    (regs),
    .int_n   (int_n)
  );

  initial begin
    RESET = 1'b0;
    forever #2 RESET = ~RESET;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  // Bit repeat c,c,c[2:1]; darkened lines are halved
  function automatic logic [7:0] expand_channel(input logic [2:0] c, input logic dark);
    logic [7:0] full;
    full = (8'(c) << 5) | (8'(c) << 2) | (8'(c) >> 1);
    return dark ? (full / 2) : full;
  endfunction

  function automatic logic [23:0] expected_rgb(input vdp_pkg::rgb9_t c, input logic dark);
    return {expand_channel(c.red, dark), expand_channel(c.green, dark),
            expand_channel(c.blue, dark)};
  endfunction

  function automatic string test_name(input logic [2:0] g);
    case (g)
      3'd0:    return "palette load";
      3'd1:    return "register access";
      3'd2:    return "palette expansion";
      3'd3:    return "display off and window edge";
      3'd4:    return "scanline darkening";
      3'd5:    return "vertical interrupt";
      default: return "line interrupt";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR %s: got %h, expected %h", name, actual, expected);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: mismatch", name);
      tests_failed++;
    end
  endtask

  // ------------------------------
  // Table building
  // ------------------------------
  function automatic void add_step(input op_t op, input logic [1:0] addr,
                                   input logic [7:0] data, input logic [9:0] bx,
                                   input logic [9:0] by, input logic [3:0] pix,
                                   input logic [23:0] expected);
    step_t s;
    s = '{cur_grp, op, addr, data, bx, by, pix, expected};
    steps.push_back(s);
  endfunction

  // Data byte, then register number with bit 7 set
  function automatic void add_reg_write(input logic [5:0] num, input logic [7:0] val);
    add_step(OP_WRITE, vdp_pkg::ADDR_CTRL, val, '0, '0, '0, 24'd0);
    add_step(OP_WRITE, vdp_pkg::ADDR_CTRL, {2'b10, num}, '0, '0, '0, 24'd0);
  endfunction

  function automatic void add_pal_pair(input vdp_pkg::rgb9_t c);
    add_step(OP_WRITE, vdp_pkg::ADDR_PAL, {1'b0, c.red, 1'b0, c.blue}, '0, '0, '0, 24'd0);
    add_step(OP_WRITE, vdp_pkg::ADDR_PAL, {5'b0, c.green}, '0, '0, '0, 24'd0);
  endfunction

  function automatic void add_beam(input logic [9:0] bx, input logic [9:0] by,
                                   input logic [3:0] pix, input logic [3:0] idx,
                                   input logic dark);
    add_step(OP_BEAM, '0, '0, bx, by, pix, expected_rgb(model_pal[idx], dark));
  endfunction

  function automatic void add_read(input logic [7:0] expected);
    add_step(OP_READ, vdp_pkg::ADDR_CTRL, '0, '0, '0, '0, 24'(expected));
  endfunction

  function automatic void add_pulse(input logic [9:0] bx, input logic [9:0] by);
    add_step(OP_PULSE, '0, '0, bx, by, '0, 24'd0);
  endfunction

  function automatic void add_intn(input logic expected);
    add_step(OP_INTN, '0, '0, '0, '0, '0, 24'(expected));
  endfunction

  task automatic build_table();
    logic [15:0]    rnd;
    logic [3:0]     idx;
    logic [9:0]     bx;
    logic [9:0]     by;
    vdp_pkg::rgb9_t c;
    // Whole palette through the auto-incrementing pointer
    cur_grp = 3'd0;
    add_reg_write(vdp_pkg::REG_R16, 8'h00);
    for (int i = 0; i < 16; i++) begin
      rnd = next_random();
      c = vdp_pkg::rgb9_t'(rnd[8:0]);
      model_pal[i] = c;
      add_pal_pair(c);
    end
    // Address 0 write must not disturb the control pair
    cur_grp = 3'd1;
    add_reg_write(vdp_pkg::REG_R7, 8'h03);
    add_beam(10'd0, 10'd0, 4'd0, 4'd3, 1'b0);
    add_step(OP_WRITE, vdp_pkg::ADDR_CTRL, 8'h05, '0, '0, '0, 24'd0);
    add_step(OP_WRITE, vdp_pkg::ADDR_DATA, 8'h87, '0, '0, '0, 24'd1);
    add_beam(10'd0, 10'd0, 4'd0, 4'd3, 1'b0);
    add_step(OP_WRITE, vdp_pkg::ADDR_CTRL, 8'h87, '0, '0, '0, 24'd0);
    add_beam(10'd0, 10'd0, 4'd0, 4'd5, 1'b0);
    add_reg_write(vdp_pkg::REG_R17, 8'h87);
    add_step(OP_WRITE, vdp_pkg::ADDR_INDIRECT, 8'h09, '0, '0, '0, 24'd0);
    add_beam(10'd0, 10'd0, 4'd0, 4'd9, 1'b0);
    cur_grp = 3'd2;
    add_reg_write(vdp_pkg::REG_R1, 8'h40);
    for (int i = 0; i < 4; i++) begin
      rnd = next_random();
      idx = rnd[3:0];
      rnd = next_random();
      c = vdp_pkg::rgb9_t'(rnd[8:0]);
      model_pal[idx] = c;
      add_reg_write(vdp_pkg::REG_R16, {4'h0, idx});
      add_pal_pair(c);
    end
    for (int i = 0; i < 8; i++) begin
      rnd = next_random();
      bx = vdp_pkg::WIN_X_START + 10'(rnd[8:0]);
      rnd = next_random();
      by = vdp_pkg::WIN_Y_START + 10'(rnd % 16'd384);
      rnd = next_random();
      add_beam(bx, by, rnd[3:0], rnd[3:0], 1'b0);
    end
    cur_grp = 3'd3;
    add_reg_write(vdp_pkg::REG_R1, 8'h00);
    add_beam(10'd200, 10'd100, 4'd12, 4'd9, 1'b0);
    add_reg_write(vdp_pkg::REG_R1, 8'h40);
    add_beam(vdp_pkg::WIN_X_END + 10'd1, 10'd100, 4'd12, 4'd9, 1'b0);
    add_beam(vdp_pkg::WIN_X_END, 10'd100, 4'd12, 4'd12, 1'b0);
    add_beam(vdp_pkg::WIN_X_START - 10'd1, 10'd100, 4'd12, 4'd9, 1'b0);
    cur_grp = 3'd4;
    add_step(OP_SCAN, '0, 8'h01, '0, '0, '0, 24'd0);
    add_beam(10'd300, 10'd101, 4'd6, 4'd6, 1'b1);
    add_beam(10'd300, 10'd102, 4'd6, 4'd6, 1'b0);
    add_beam(10'd10, 10'd11, 4'd6, 4'd9, 1'b1);
    add_step(OP_SCAN, '0, 8'h00, '0, '0, '0, 24'd0);
    add_beam(10'd300, 10'd101, 4'd6, 4'd6, 1'b0);
    // NTSC first, then PAL
    cur_grp = 3'd5;
    add_reg_write(vdp_pkg::REG_R1, 8'h60);
    for (int std = 0; std < 2; std++) begin
      add_reg_write(vdp_pkg::REG_R9, (std == 1) ? 8'h02 : 8'h00);
      add_pulse(10'd0, (std == 1) ? vdp_pkg::VBLANK_LINE_PAL : vdp_pkg::VBLANK_LINE_NTSC);
      add_intn(1'b0);
      add_read(8'h80);
      add_intn(1'b1);
      add_read(8'h00);
    end
    add_reg_write(vdp_pkg::REG_R9, 8'h00);
    cur_grp = 3'd6;
    add_reg_write(vdp_pkg::REG_R1, 8'h40);
    add_reg_write(vdp_pkg::REG_R0, 8'h10);
    add_reg_write(vdp_pkg::REG_R19, 8'd5);
    add_reg_write(vdp_pkg::REG_R15, 8'h01);
    add_pulse(vdp_pkg::HINT_X, vdp_pkg::WIN_Y_START + 10'd10);
    add_intn(1'b0);
    add_read(8'h01);
    add_intn(1'b1);
    add_read(8'h00);
    add_reg_write(vdp_pkg::REG_R0, 8'h00);
    add_pulse(vdp_pkg::HINT_X, vdp_pkg::WIN_Y_START + 10'd10);
    add_intn(1'b1);
    add_read(8'h01);
    add_read(8'h00);
  endtask

  // ------------------------------
  // Bus and beam drivers
  // ------------------------------
  task automatic apb_transfer(input logic write, input logic [1:0] addr,
                              input logic [7:0] wdata, output logic [7:0] rdata,
                              output logic slverr);
    vdp_pkg::apb_req_t req;
    int                wait_cycles;
    req = '{1'b1, 1'b0, write, addr, wdata};
    @(posedge RESET);
    apb_req <= req;
    @(posedge RESET);
    apb_req.penable <= 1'b1;
    @(negedge RESET);
    wait_cycles = 0;
    while (!apb_rsp.pready && wait_cycles < 16) begin
      @(negedge RESET);
      wait_cycles++;
    end
    if (!apb_rsp.pready) begin
      $display("APB transfer to address %0d never got pready", addr);
      errors++;
    end
    rdata = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge RESET);
    apb_req <= '0;
  endtask

  task automatic drive_beam(input logic [9:0] bx, input logic [9:0] by, input logic [3:0] pix);
    @(posedge RESET);
    cx         <= bx;
    cy         <= by;
    pixel_code <= pix;
  endtask

  task automatic run_step(input step_t s);
    logic [7:0] rdata;
    logic       slverr;
    case (s.op)
      OP_WRITE: begin
        apb_transfer(1'b1, s.addr, s.data, rdata, slverr);
        check_value("pslverr", 32'(slverr), 32'(s.expected));
      end
      OP_READ: begin
        apb_transfer(1'b0, s.addr, 8'h00, rdata, slverr);
        check_value("prdata", 32'(rdata), 32'(s.expected));
        check_value("pslverr", 32'(slverr), 32'd0);
      end
      OP_BEAM: begin
        // Two-cycle pipeline from beam to RGB
        drive_beam(s.cx, s.cy, s.pix);
        repeat (2) @(posedge RESET);
        @(negedge RESET);
        check_value("rgb", 32'({red, green, blue}), 32'(s.expected));
      end
      OP_PULSE: begin
        drive_beam(s.cx, s.cy, s.pix);
        drive_beam(s.cx + 10'd1, s.cy, s.pix);
      end
      OP_INTN: begin
        repeat (2) @(posedge RESET);
        @(negedge RESET);
        check_value("int_n", 32'(int_n), 32'(s.expected));
      end
      default: begin
        @(posedge RESET);
        scanlin <= s.data[0];
      end
    endcase
  endtask

  // ------------------------------
  // Main sequence and watchdog
  // ------------------------------
  initial begin
    table_ready = 1'b0;
    wait (table_ready === 1'b1);
    repeat (steps.size() * 40) @(posedge RESET);
    $display("Run timed out before the test table was finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    CLK21M       = 1'b1;
    apb_req      = '0;
    cx           = '0;
    cy           = '0;
    pixel_code   = '0;
    scanlin      = 1'b0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    lcg_state    = 32'd10;
    cur_grp      = 3'd0;
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge RESET);
    CLK21M <= 1'b0;
    group_start = errors;
    for (int i = 0; i < steps.size(); i++) begin
      run_step(steps[i]);
      if (i == steps.size() - 1 || steps[i + 1].grp != steps[i].grp) begin
        report_test(test_name(steps[i].grp), group_start);
        group_start = errors;
      end
    end
    check_value("assertion_failures", 32'(u_dut.u_assertions.fail_count), 32'd0);
    report_test("assertions", group_start);
    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
logic/vdp_pkg.sv
logic/vdp_cpu_port.sv
logic/vdp_interrupt.sv
logic/vdp_display_window.sv
logic/vdp_color_out.sv
logic/vdp_top.sv
tb/vdp_assertions.sv
tb/tb_vdp.sv
